// ==== vlog.f ====
source/pixel_buffer_pkg.sv
source/image_bank.sv
source/bank_array.sv
source/load_engine.sv
source/readback_engine.sv
source/transfer_sequencer.sv
source/status_display.sv
source/pixel_buffer_top.sv
tests/tb_pixel_buffer.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the pixel buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_pixel_buffer \
	-o tb_pixel_buffer && ./obj_dir/tb_pixel_buffer > sim.log 2>&1 \
	|| echo "Build or simulation did not complete" >> sim.log
cat sim.log
# A missing pass line also counts as failure
grep -q "RESULT: FAIL" sim.log && exit 1 || grep -q "RESULT: PASS" sim.log || exit 1

// ==== tests/tb_pixel_buffer.sv ====
`timescale 1ns/10ps

module tb_pixel_buffer;
	import pixel_buffer_pkg::*;

	logic        clk;
	logic        rst_n;
	pixel_beat_t wr_beat;
	logic        wr_credit;
	logic        rd_credit;
	pixel_beat_t rd_beat;
	logic        done;
	seg_t        hex0;
	seg_t        hex1;
	seg_t        hex2;

	// Written pixels in send order
	pixel_t sent_q[$];
	pixel_t exp_pix;

	// Host and monitor bookkeeping
	int wr_creds;
	int credit_pulses;
	int credits_granted;
	int beats_seen;

	// Error counts
	int mismatch_errs;
	int check_errs;
	int timeout_errs;

	pixel_buffer_top dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_beat  (wr_beat),
		.wr_credit(wr_credit),
		.rd_credit(rd_credit),
		.rd_beat  (rd_beat),
		.done     (done),
		.hex0     (hex0),
		.hex1     (hex1),
		.hex2     (hex2)
	);

	always #2 clk = ~clk;

	////////////////////////////////////////
	// Monitors
	////////////////////////////////////////

	// Read credits counted on the edge the DUT samples them
	always @(posedge clk) begin
		if (rst_n && rd_credit) begin
			credits_granted <= credits_granted + 1;
		end
	end

	// Outputs are stable mid-cycle
	always @(negedge clk) begin
		if (rst_n) begin
			if (wr_credit) begin
				credit_pulses++;
			end
			if (rd_beat.valid) begin
				// Beat must be covered by a credit already granted
				a_beat_has_credit: assert (beats_seen < credits_granted) else begin
					check_errs++;
					$display("Read beat %0d arrived without a read credit", beats_seen);
				end
				if (sent_q.size() == 0) begin
					check_errs++;
					$display("Read beat %0d arrived with no pixel left to return", beats_seen);
				end else begin
					exp_pix = sent_q.pop_front();
					a_pixel_order: assert (rd_beat.pixel == exp_pix) else begin
						mismatch_errs++;
						$display("Mismatch rd_beat.pixel beat %0d: expected %h, got %h",
							beats_seen, exp_pix, rd_beat.pixel);
					end
				end
				beats_seen++;
			end
		end
	end

	////////////////////////////////////////
	// Protocol checks
	////////////////////////////////////////

	// Quiet outputs in reset and the first cycle after
	a_quiet_in_reset: assert property (@(posedge clk)
		!rst_n |=> !wr_credit && !rd_beat.valid && !done) else begin
		check_errs++;
		$display("Output active while reset is asserted");
	end

	a_quiet_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |=> !wr_credit && !rd_beat.valid && !done) else begin
		check_errs++;
		$display("Output active in the first cycle after reset");
	end

	a_host_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
		wr_creds >= 0 && wr_creds <= wr_credits) else begin
		check_errs++;
		$display("Host write credits out of range at %0d", $sampled(wr_creds));
	end

	a_done_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> done) else begin
		check_errs++;
		$display("done dropped after it was raised");
	end

	a_quiet_after_done: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> !rd_beat.valid) else begin
		check_errs++;
		$display("Read beat appeared after done");
	end

	a_all_beats_read: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> beats_seen == frame_pixels) else begin
		mismatch_errs++;
		$display("Mismatch beats_seen: expected %h, got %h",
			frame_pixels, $sampled(beats_seen));
	end

	a_all_credits_back: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> credit_pulses == frame_pixels) else begin
		mismatch_errs++;
		$display("Mismatch wr_credit pulses: expected %h, got %h",
			frame_pixels, $sampled(credit_pulses));
	end

	// Glyph 4 for s_done and glyph 0 for both counts at 128
	a_hex0_done: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> hex0 == 7'b0011001) else begin
		mismatch_errs++;
		$display("Mismatch hex0: expected %h, got %h", 7'b0011001, $sampled(hex0));
	end

	a_hex1_done: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> hex1 == 7'b1000000) else begin
		mismatch_errs++;
		$display("Mismatch hex1: expected %h, got %h", 7'b1000000, $sampled(hex1));
	end

	a_hex2_done: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> hex2 == 7'b1000000) else begin
		mismatch_errs++;
		$display("Mismatch hex2: expected %h, got %h", 7'b1000000, $sampled(hex2));
	end

	////////////////////////////////////////
	// Host model
	////////////////////////////////////////

	// Write side with random gaps and never beyond the credits held
	task automatic send_frame();
		int sent;
		int cycles;
		pixel_t pix;
		sent = 0;
		cycles = 0;
		while (sent < frame_pixels && cycles < 2000) begin
			@(negedge clk);
			cycles++;
			wr_beat.valid = 1'b0;
			if (wr_creds > 0 && ($urandom % 4) != 0) begin
				pix = pixel_t'($urandom);
				wr_beat.valid = 1'b1;
				wr_beat.pixel = pix;
				sent_q.push_back(pix);
				wr_creds--;
				sent++;
			end
			// Returned credit usable from the next cycle
			if (wr_credit) begin
				wr_creds++;
			end
		end
		// Frame is in the banks once every credit is back
		cycles = 0;
		while (wr_creds < wr_credits && cycles < 100) begin
			@(negedge clk);
			cycles++;
			wr_beat.valid = 1'b0;
			if (wr_credit) begin
				wr_creds++;
			end
		end
		if (sent < frame_pixels || wr_creds < wr_credits) begin
			timeout_errs++;
			$display("Timed out loading the frame, %0d pixels sent", sent);
		end
	endtask

	// Read side with random grants and one long starvation gap
	task automatic grant_read_credits();
		int granted;
		int cycles;
		int gap;
		bit paused;
		granted = 0;
		cycles = 0;
		paused = 0;
		while (granted < frame_pixels && cycles < 4000) begin
			@(negedge clk);
			cycles++;
			rd_credit = 1'b0;
			if (granted == frame_pixels / 2 && !paused) begin
				paused = 1;
				for (gap = 0; gap < 24; gap++) begin
					@(negedge clk);
				end
			end else if (($urandom % 3) != 0) begin
				rd_credit = 1'b1;
				granted++;
			end
		end
		@(negedge clk);
		rd_credit = 1'b0;
		if (granted < frame_pixels) begin
			timeout_errs++;
			$display("Timed out granting read credits, %0d granted", granted);
		end
	endtask

	task automatic wait_for_done();
		int cycles;
		cycles = 0;
		while (!done && cycles < 300) begin
			@(negedge clk);
			cycles++;
		end
		if (!done) begin
			timeout_errs++;
			$display("Timed out waiting for done");
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		int i;
		void'($urandom(32'h1f315dfb));
		clk = 1'b0;
		rst_n = 1'b0;
		wr_beat = '0;
		rd_credit = 1'b0;
		wr_creds = wr_credits;
		credit_pulses = 0;
		credits_granted = 0;
		beats_seen = 0;
		mismatch_errs = 0;
		check_errs = 0;
		timeout_errs = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		send_frame();
		if (timeout_errs == 0) begin
			grant_read_credits();
		end
		if (timeout_errs == 0) begin
			wait_for_done();
		end
		// Spare credits after the frame must draw no beat
		for (i = 0; i < 16; i++) begin
			@(negedge clk);
			rd_credit = (i < 8) && (i % 2 == 0);
		end
		a_queue_drained: assert (sent_q.size() == 0) else begin
			check_errs++;
			$display("%0d written pixels were never read back", sent_q.size());
		end
		$display("Errors: %0d mismatch, %0d protocol, %0d timeout",
			mismatch_errs, check_errs, timeout_errs);
		if (mismatch_errs + check_errs + timeout_errs == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== source/pixel_buffer_top.sv ====
`timescale 1ns/10ps

module pixel_buffer_top (
	input  logic                         clk,
	input  logic                         rst_n,
	input  pixel_buffer_pkg::pixel_beat_t wr_beat,
	output logic                         wr_credit,
	input  logic                         rd_credit,
	output pixel_buffer_pkg::pixel_beat_t rd_beat,
	output logic                         done,
	output pixel_buffer_pkg::seg_t        hex0,
	output pixel_buffer_pkg::seg_t        hex1,
	output pixel_buffer_pkg::seg_t        hex2
);
	import pixel_buffer_pkg::*;

	// Sequencer handshake
	logic         load_start, read_start;
	logic         load_done, read_done;
	seq_state_t   state;
	pixel_count_t load_count, read_count;

	// Bank array ports
	bank_idx_t  wr_bank, rd_bank;
	word_addr_t wr_addr, rd_addr;
	pixel_t     wr_data, rd_data;
	logic       wr_en, rd_en;

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	transfer_sequencer u_seq (
		.clk       (clk),
		.rst_n     (rst_n),
		.load_done (load_done),
		.read_done (read_done),
		.load_start(load_start),
		.read_start(read_start),
		.state     (state),
		.done      (done)
	);

	////////////////////////////////////////
	// Datapath
	////////////////////////////////////////

	load_engine u_load (
		.clk       (clk),
		.rst_n     (rst_n),
		.load_start(load_start),
		.wr_beat   (wr_beat),
		.wr_credit (wr_credit),
		.wr_bank   (wr_bank),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.wr_en     (wr_en),
		.load_done (load_done),
		.load_count(load_count)
	);

	readback_engine u_read (
		.clk       (clk),
		.rst_n     (rst_n),
		.read_start(read_start),
		.rd_credit (rd_credit),
		.rd_bank   (rd_bank),
		.rd_addr   (rd_addr),
		.rd_en     (rd_en),
		.rd_data   (rd_data),
		.rd_beat   (rd_beat),
		.read_done (read_done),
		.read_count(read_count)
	);

	bank_array u_banks (
		.clk    (clk),
		.wr_bank(wr_bank),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_en  (wr_en),
		.rd_bank(rd_bank),
		.rd_addr(rd_addr),
		.rd_en  (rd_en),
		.rd_data(rd_data)
	);

	// Board digits
	status_display u_status (
		.state     (state),
		.load_count(load_count),
		.read_count(read_count),
		.hex0      (hex0),
		.hex1      (hex1),
		.hex2      (hex2)
	);

endmodule

// ==== source/status_display.sv ====
`timescale 1ns/10ps

module status_display (
	input  pixel_buffer_pkg::seq_state_t   state,
	input  pixel_buffer_pkg::pixel_count_t load_count,
	input  pixel_buffer_pkg::pixel_count_t read_count,
	output pixel_buffer_pkg::seg_t         hex0,
	output pixel_buffer_pkg::seg_t         hex1,
	output pixel_buffer_pkg::seg_t         hex2
);
	import pixel_buffer_pkg::*;

	// Hex glyph, segments gfedcba, low lights
	function automatic seg_t hex_glyph(input logic [3:0] nib);
		case (nib)
			4'h0:    hex_glyph = 7'b1000000;
			4'h1:    hex_glyph = 7'b1111001;
			4'h2:    hex_glyph = 7'b0100100;
			4'h3:    hex_glyph = 7'b0110000;
			4'h4:    hex_glyph = 7'b0011001;
			4'h5:    hex_glyph = 7'b0010010;
			4'h6:    hex_glyph = 7'b0000010;
			4'h7:    hex_glyph = 7'b1111000;
			4'h8:    hex_glyph = 7'b0000000;
			4'h9:    hex_glyph = 7'b0010000;
			4'hA:    hex_glyph = 7'b0001000;
			4'hB:    hex_glyph = 7'b0000011;
			4'hC:    hex_glyph = 7'b1000110;
			4'hD:    hex_glyph = 7'b0100001;
			4'hE:    hex_glyph = 7'b0000110;
			default: hex_glyph = 7'b0001110;
		endcase
	endfunction

	// Phase code, then low nibbles of both counts
	assign hex0 = hex_glyph(state);
	assign hex1 = hex_glyph(load_count[3:0]);
	assign hex2 = hex_glyph(read_count[3:0]);

endmodule

// ==== source/transfer_sequencer.sv ====
`timescale 1ns/10ps

module transfer_sequencer (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        load_done,
	input  logic                        read_done,
	output logic                        load_start,
	output logic                        read_start,
	output pixel_buffer_pkg::seq_state_t state,
	output logic                        done
);
	import pixel_buffer_pkg::*;

	////////////////////////////////////////
	// Phase FSM
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= s_clear;
			load_start <= 1'b0;
			read_start <= 1'b0;
		end else begin
			// Start pulses last one cycle
			load_start <= 1'b0;
			read_start <= 1'b0;
			case (state)
				s_clear: begin
					state      <= s_load;
					load_start <= 1'b1;
				end
				// Stale done still visible during the start cycle
				s_load: begin
					if (load_done && !load_start) begin
						state <= s_settle;
					end
				end
				s_settle: begin
					state      <= s_readback;
					read_start <= 1'b1;
				end
				s_readback: begin
					if (read_done && !read_start) begin
						state <= s_done;
					end
				end
				s_done:  state <= s_done;
				default: state <= s_clear;
			endcase
		end
	end

	assign done = (state == s_done);

	// Readback only over a fully loaded frame
	a_read_after_load: assert property (@(posedge clk) disable iff (!rst_n)
		read_start |-> load_done);

endmodule

// ==== source/readback_engine.sv ====
`timescale 1ns/10ps

module readback_engine (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          read_start,
	input  logic                          rd_credit,
	output pixel_buffer_pkg::bank_idx_t    rd_bank,
	output pixel_buffer_pkg::word_addr_t   rd_addr,
	output logic                          rd_en,
	input  pixel_buffer_pkg::pixel_t       rd_data,
	output pixel_buffer_pkg::pixel_beat_t  rd_beat,
	output logic                          read_done,
	output pixel_buffer_pkg::pixel_count_t read_count
);
	import pixel_buffer_pkg::*;

	pixel_count_t credit_cnt;
	logic         issuing;
	logic         beat_valid;

	////////////////////////////////////////
	// Credit tracking
	////////////////////////////////////////

	// Granted credits not yet spent on a delivered beat
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credit_cnt <= '0;
		end else begin
			credit_cnt <= credit_cnt + pixel_count_t'(rd_credit) - pixel_count_t'(beat_valid);
		end
	end

	// beat_valid is the read still in flight
	assign rd_en = issuing && (credit_cnt > pixel_count_t'(beat_valid));

	////////////////////////////////////////
	// Read issue, frame order
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			issuing <= 1'b0;
			rd_bank <= '0;
			rd_addr <= '0;
		end else if (read_start) begin
			issuing <= 1'b1;
			rd_bank <= '0;
			rd_addr <= '0;
		end else if (rd_en) begin
			if (rd_addr == word_addr_t'(row_pixels - 1)) begin
				rd_addr <= '0;
				rd_bank <= rd_bank + 1'b1;
				// last word of the last bank
				if (rd_bank == bank_idx_t'(num_banks - 1)) begin
					issuing <= 1'b0;
				end
			end else begin
				rd_addr <= rd_addr + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Returned beat
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beat_valid <= 1'b0;
			read_count <= '0;
			read_done  <= 1'b0;
		end else begin
			beat_valid <= rd_en;
			if (read_start) begin
				read_count <= '0;
				read_done  <= 1'b0;
			end else if (beat_valid) begin
				read_count <= read_count + 1'b1;
				if (read_count == pixel_count_t'(frame_pixels - 1)) begin
					read_done <= 1'b1;
				end
			end
		end
	end

	// Bank output already registered, valid matches its latency
	assign rd_beat = '{valid: beat_valid, pixel: rd_data};

	// Every delivered beat was paid for
	a_credit_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		beat_valid |-> credit_cnt != '0);

endmodule

// ==== source/load_engine.sv ====
`timescale 1ns/10ps

module load_engine (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          load_start,
	input  pixel_buffer_pkg::pixel_beat_t  wr_beat,
	output logic                          wr_credit,
	output pixel_buffer_pkg::bank_idx_t    wr_bank,
	output pixel_buffer_pkg::word_addr_t   wr_addr,
	output pixel_buffer_pkg::pixel_t       wr_data,
	output logic                          wr_en,
	output logic                          load_done,
	output pixel_buffer_pkg::pixel_count_t load_count
);
	import pixel_buffer_pkg::*;

	pixel_t                          fifo_mem [wr_credits];
	logic [$clog2(wr_credits)-1:0]   head;
	logic [$clog2(wr_credits)-1:0]   tail;
	logic [$clog2(wr_credits+1)-1:0] fill;
	logic                            active;

	////////////////////////////////////////
	// Credit FIFO
	////////////////////////////////////////

	// Beats land here even before the load starts
	always_ff @(posedge clk) begin
		if (wr_beat.valid) begin
			fifo_mem[tail] <= wr_beat.pixel;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head <= '0;
			tail <= '0;
			fill <= '0;
		end else begin
			if (wr_beat.valid) begin
				tail <= (tail == wr_credits - 1) ? '0 : tail + 1'b1;
			end
			if (wr_en) begin
				head <= (head == wr_credits - 1) ? '0 : head + 1'b1;
			end
			case ({wr_beat.valid, wr_en})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	// Drain one word per cycle from the head
	assign wr_en   = active && (fill != '0);
	assign wr_data = fifo_mem[head];

	// Freed slot goes straight back to the host
	assign wr_credit = wr_en;

	////////////////////////////////////////
	// Bank and address generator
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active     <= 1'b0;
			load_done  <= 1'b0;
			wr_bank    <= '0;
			wr_addr    <= '0;
			load_count <= '0;
		end else if (load_start) begin
			active     <= 1'b1;
			load_done  <= 1'b0;
			wr_bank    <= '0;
			wr_addr    <= '0;
			load_count <= '0;
		end else if (wr_en) begin
			load_count <= load_count + 1'b1;
			// Row full, next bank
			if (wr_addr == word_addr_t'(row_pixels - 1)) begin
				wr_addr <= '0;
				wr_bank <= wr_bank + 1'b1;
			end else begin
				wr_addr <= wr_addr + 1'b1;
			end
			// Last pixel of the frame
			if (load_count == pixel_count_t'(frame_pixels - 1)) begin
				active    <= 1'b0;
				load_done <= 1'b1;
			end
		end
	end

	// Host keeps within its credits
	a_fifo_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		wr_beat.valid |-> fill < wr_credits);

	// Frame complete, banks left alone
	a_no_write_after_done: assert property (@(posedge clk) disable iff (!rst_n)
		load_done |-> !wr_en);

endmodule

// ==== source/bank_array.sv ====
`timescale 1ns/10ps

module bank_array (
	input  logic                        clk,
	input  pixel_buffer_pkg::bank_idx_t  wr_bank,
	input  pixel_buffer_pkg::word_addr_t wr_addr,
	input  pixel_buffer_pkg::pixel_t     wr_data,
	input  logic                        wr_en,
	input  pixel_buffer_pkg::bank_idx_t  rd_bank,
	input  pixel_buffer_pkg::word_addr_t rd_addr,
	input  logic                        rd_en,
	output pixel_buffer_pkg::pixel_t     rd_data
);
	import pixel_buffer_pkg::*;

	logic [num_banks-1:0] wr_sel;
	logic [num_banks-1:0] rd_sel;
	logic [num_banks-1:0] rd_sel_q;
	pixel_t               bank_q [num_banks];

	////////////////////////////////////////
	// Bank select decode
	////////////////////////////////////////

	// One-hot, write enable folded in
	assign wr_sel = wr_en ? (num_banks'(1) << wr_bank) : '0;
	assign rd_sel = num_banks'(1) << rd_bank;

	// Select travels with the read, lines up with bank q
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_sel_q <= rd_sel;
		end
	end

	// Address and data broadcast, only one bank enabled
	for (genvar b = 0; b < num_banks; b++) begin : g_bank
		image_bank #(
			.width(pixel_w),
			.depth(row_pixels)
		) u_bank (
			.clk  (clk),
			.we   (wr_sel[b]),
			.waddr(wr_addr),
			.d    (wr_data),
			.raddr(rd_addr),
			.q    (bank_q[b])
		);
	end

	// AND-OR mux on the registered one-hot select
	always_comb begin
		rd_data = '0;
		for (int b = 0; b < num_banks; b++) begin
			if (rd_sel_q[b]) begin
				rd_data = rd_data | bank_q[b];
			end
		end
	end

endmodule

// ==== source/image_bank.sv ====
`timescale 1ns/10ps

module image_bank #(
	parameter int width = 9,
	parameter int depth = 16
) (
	input  logic                     clk,
	input  logic                     we,
	input  logic [$clog2(depth)-1:0] waddr,
	input  logic [width-1:0]         d,
	input  logic [$clog2(depth)-1:0] raddr,
	output logic [width-1:0]         q
);

	// Storage only, maps onto block RAM
	logic [width-1:0] mem [depth];

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= d;
		end
	end

	////////////////////////////////////////
	// Read port
	////////////////////////////////////////

	// Registered read, one cycle latency
	// Same-address write in this cycle is not seen yet
	always_ff @(posedge clk) begin
		q <= mem[raddr];
	end

endmodule

// ==== source/pixel_buffer_pkg.sv ====
package pixel_buffer_pkg;

	////////////////////////////////////////
	// Frame geometry
	////////////////////////////////////////

	// One bank per image row
	localparam int num_banks    = 8;
	localparam int row_pixels   = 16;
	localparam int frame_pixels = num_banks * row_pixels;

	// Write FIFO depth, equal to the host's starting credits
	localparam int wr_credits = 4;

	localparam int pixel_w = 9;

	////////////////////////////////////////
	// Types
	////////////////////////////////////////

	typedef logic [pixel_w-1:0] pixel_t;
	typedef logic [2:0]         bank_idx_t;
	typedef logic [3:0]         word_addr_t;
	typedef logic [7:0]         pixel_count_t;

	// Active-low segments, bit 0 is segment a
	typedef logic [6:0] seg_t;

	// One pixel on either host channel
	typedef struct packed {
		logic   valid;
		pixel_t pixel;
	} pixel_beat_t;

	// Sequencer phases, code shown on hex0
	typedef enum logic [3:0] {
		s_clear    = 4'd0,
		s_load     = 4'd1,
		s_settle   = 4'd2,
		s_readback = 4'd3,
		s_done     = 4'd4
	} seq_state_t;

endpackage
